/* logic/img_geom_pkg.sv */
`default_nettype none

package img_geom_pkg;

  // one grey pixel, unsigned
  localparam int PIX_W = 8;

  typedef logic [PIX_W-1:0] pixel_t;

  // default image geometry
  // 4 strips of 4 pixels give a 128 bit row word
  localparam int DEF_IMG_ROWS = 8;
  localparam int DEF_STRIPS   = 4;
  localparam int DEF_STRIP_PX = 4;

  // rows are stored one word per address, strip 0 in the low bits
  // pixel c of a row sits at bits [c*PIX_W +: PIX_W]

endpackage

`default_nettype wire

/* logic/blur_kernel_pkg.sv */
`default_nettype none

package blur_kernel_pkg;

  // binomial taps, same along rows and columns
  localparam int W_EDGE   = 1;
  localparam int W_CENTER = 2;

  // sum of all nine weights of the 3x3 kernel
  localparam int KERNEL_SUM = (2 * W_EDGE + W_CENTER) * (2 * W_EDGE + W_CENTER);

  // divide by the kernel sum, round half up
  localparam int NORM_SHIFT = $clog2(KERNEL_SUM);
  localparam int NORM_ROUND = 1 << (NORM_SHIFT - 1);

  // worst case: all taps at full scale plus the rounding add
  // still fits in PIX_W + NORM_SHIFT bits

endpackage

`default_nettype wire

/* logic/blur_ctrl_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module blur_ctrl_fsm #(
  parameter int IMG_ROWS = img_geom_pkg::DEF_IMG_ROWS,
  parameter int STRIPS   = img_geom_pkg::DEF_STRIPS
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  output logic                        done,
  output logic                        img_rd,
  output logic [$clog2(IMG_ROWS)-1:0] img_addr,
  output logic                        lb_shift,
  output logic                        fill_zero,
  output logic                        win_clear,
  output logic [$clog2(STRIPS)-1:0]   strip_idx,
  output logic [$clog2(IMG_ROWS)-1:0] blur_raddr,
  output logic                        blur_we,
  output logic [$clog2(IMG_ROWS)-1:0] blur_waddr
);

  localparam int RA_W = $clog2(IMG_ROWS);
  localparam int SI_W = $clog2(STRIPS);

  localparam logic [RA_W:0]   ROW_END    = (RA_W + 1)'(IMG_ROWS);
  localparam logic [RA_W-1:0] LAST_ROW   = RA_W'(IMG_ROWS - 1);
  localparam logic [SI_W-1:0] LAST_STRIP = SI_W'(STRIPS - 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_PREFETCH,
    S_ROWS,
    S_NEXT
  } state_t;

  state_t state;
  state_t state_nxt;

  logic            pf_cnt;
  // one extra bit so the counter can park at IMG_ROWS while the pipe drains
  logic [RA_W:0]   row_cnt;
  logic [RA_W:0]   fetch_row;
  logic            row_live;
  logic            zero_req;
  logic            last_wr;
  // write pipe: read stage, kernel stage, then blur_we
  logic            rd_vld;
  logic            kern_vld;
  logic [RA_W-1:0] kern_row;

  // image reads run two rows ahead of the window centre
  assign row_live  = (state == S_ROWS) && (row_cnt < ROW_END);
  assign fetch_row = row_cnt + (RA_W + 1)'(2);
  assign img_rd    = (state == S_PREFETCH) || (row_live && (fetch_row < ROW_END));
  assign zero_req  = row_live && (fetch_row >= ROW_END);
  assign img_addr  = (state == S_PREFETCH) ? RA_W'(pf_cnt) : fetch_row[RA_W-1:0];

  // window starts empty, which is the zero row above row 0
  assign win_clear = (state == S_PREFETCH) && !pf_cnt;

  assign last_wr = blur_we && (blur_waddr == LAST_ROW);

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (start) begin
          state_nxt = S_PREFETCH;
        end
      end
      S_PREFETCH: begin
        if (pf_cnt) begin
          state_nxt = S_ROWS;
        end
      end
      S_ROWS: begin
        // strip ends with its last write, not with its last read
        if (last_wr) begin
          state_nxt = (strip_idx == LAST_STRIP) ? S_IDLE : S_NEXT;
        end
      end
      S_NEXT: begin
        state_nxt = S_PREFETCH;
      end
      default: begin
        state_nxt = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      pf_cnt    <= 1'b0;
      row_cnt   <= '0;
      strip_idx <= '0;
    end else begin
      state <= state_nxt;
      case (state)
        S_IDLE: begin
          pf_cnt    <= 1'b0;
          strip_idx <= '0;
        end
        S_PREFETCH: begin
          pf_cnt  <= ~pf_cnt;
          row_cnt <= '0;
        end
        S_ROWS: begin
          if (row_live) begin
            row_cnt <= row_cnt + 1'b1;
          end
        end
        S_NEXT: begin
          strip_idx <= strip_idx + 1'b1;
        end
        default: begin
          pf_cnt <= 1'b0;
        end
      endcase
    end
  end

  // strobes, all low out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lb_shift  <= 1'b0;
      fill_zero <= 1'b0;
      rd_vld    <= 1'b0;
      kern_vld  <= 1'b0;
      blur_we   <= 1'b0;
      done      <= 1'b0;
    end else begin
      // sram data lands one cycle after img_rd, zero rows use the same slot
      lb_shift  <= img_rd || zero_req;
      fill_zero <= zero_req;
      rd_vld    <= row_live;
      kern_vld  <= rd_vld;
      blur_we   <= kern_vld;
      done      <= last_wr && (strip_idx == LAST_STRIP);
    end
  end

  // row address follows the window centre through the pipe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_raddr <= '0;
      kern_row   <= '0;
      blur_waddr <= '0;
    end else begin
      blur_raddr <= row_cnt[RA_W-1:0];
      kern_row   <= blur_raddr;
      blur_waddr <= kern_row;
    end
  end

endmodule

`default_nettype wire

/* logic/line_window.sv */
`timescale 1ns/10ps
`default_nettype none

module line_window #(
  parameter int  STRIPS   = img_geom_pkg::DEF_STRIPS,
  parameter int  STRIP_PX = img_geom_pkg::DEF_STRIP_PX,
  localparam int WORD_W   = STRIPS * STRIP_PX * img_geom_pkg::PIX_W
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              lb_shift,
  input  logic              fill_zero,
  input  logic              clear,
  input  logic [WORD_W-1:0] img_dout,
  output logic [WORD_W-1:0] row_above,
  output logic [WORD_W-1:0] row_mid,
  output logic [WORD_W-1:0] row_below
);

  // row entering at the bottom of the window
  logic [WORD_W-1:0] row_in;

  // zero rows pad the image below its last row
  assign row_in = fill_zero ? '0 : img_dout;

  // three deep shift, oldest row on top
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      row_above <= '0;
      row_mid   <= '0;
      row_below <= '0;
    end else if (lb_shift) begin
      row_above <= row_mid;
      row_mid   <= row_below;
      row_below <= row_in;
    end
  end

endmodule

`default_nettype wire

/* logic/gauss_3x3_kernel.sv */
`timescale 1ns/10ps
`default_nettype none

module gauss_3x3_kernel #(
  parameter int  STRIPS   = img_geom_pkg::DEF_STRIPS,
  parameter int  STRIP_PX = img_geom_pkg::DEF_STRIP_PX,
  localparam int WORD_W   = STRIPS * STRIP_PX * img_geom_pkg::PIX_W
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [WORD_W-1:0]                    row_above,
  input  logic [WORD_W-1:0]                    row_mid,
  input  logic [WORD_W-1:0]                    row_below,
  input  logic [$clog2(STRIPS)-1:0]            strip_idx,
  output img_geom_pkg::pixel_t [STRIP_PX-1:0]  strip_out
);

  import img_geom_pkg::*;
  import blur_kernel_pkg::*;

  localparam int STRIP_W = STRIP_PX * PIX_W;
  // strip plus one neighbour pixel on each side
  localparam int NB_W    = STRIP_W + 2 * PIX_W;
  localparam int EXT_W   = WORD_W + 2 * PIX_W;
  localparam int ACC_W   = PIX_W + NORM_SHIFT;

  logic [EXT_W-1:0] ext_above;
  logic [EXT_W-1:0] ext_mid;
  logic [EXT_W-1:0] ext_below;
  logic [NB_W-1:0]  nb_above;
  logic [NB_W-1:0]  nb_mid;
  logic [NB_W-1:0]  nb_below;
  logic [ACC_W-1:0] col_sum [STRIP_PX+2];
  logic [ACC_W-1:0] acc [STRIP_PX];
  pixel_t [STRIP_PX-1:0] blur_px;

  // zero pixel left of column 0 and right of the last column
  assign ext_above = {{PIX_W{1'b0}}, row_above, {PIX_W{1'b0}}};
  assign ext_mid   = {{PIX_W{1'b0}}, row_mid, {PIX_W{1'b0}}};
  assign ext_below = {{PIX_W{1'b0}}, row_below, {PIX_W{1'b0}}};

  // the low pad shifts the slice down by one pixel, so it starts at column -1
  assign nb_above = ext_above[strip_idx * STRIP_W +: NB_W];
  assign nb_mid   = ext_mid[strip_idx * STRIP_W +: NB_W];
  assign nb_below = ext_below[strip_idx * STRIP_W +: NB_W];

  // vertical pass first
  for (genvar j = 0; j < STRIP_PX + 2; j++) begin : g_col
    assign col_sum[j] = ACC_W'(W_EDGE * nb_above[j*PIX_W +: PIX_W])
                      + ACC_W'(W_CENTER * nb_mid[j*PIX_W +: PIX_W])
                      + ACC_W'(W_EDGE * nb_below[j*PIX_W +: PIX_W]);
  end

  // then horizontal, round and normalise
  for (genvar p = 0; p < STRIP_PX; p++) begin : g_px
    assign acc[p] = ACC_W'(W_EDGE * col_sum[p])
                  + ACC_W'(W_CENTER * col_sum[p+1])
                  + ACC_W'(W_EDGE * col_sum[p+2])
                  + ACC_W'(NORM_ROUND);
    assign blur_px[p] = pixel_t'(acc[p] >> NORM_SHIFT);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      strip_out <= '0;
    end else begin
      strip_out <= blur_px;
    end
  end

endmodule

`default_nettype wire

/* logic/strip_merge.sv */
`timescale 1ns/10ps
`default_nettype none

module strip_merge #(
  parameter int  STRIPS   = img_geom_pkg::DEF_STRIPS,
  parameter int  STRIP_PX = img_geom_pkg::DEF_STRIP_PX,
  localparam int WORD_W   = STRIPS * STRIP_PX * img_geom_pkg::PIX_W
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  img_geom_pkg::pixel_t [STRIP_PX-1:0] strip_out,
  input  logic [$clog2(STRIPS)-1:0]           strip_idx,
  input  logic [WORD_W-1:0]                   blur_dout,
  output logic [WORD_W-1:0]                   blur_din
);

  import img_geom_pkg::*;

  localparam int STRIP_W = STRIP_PX * PIX_W;
  localparam int SI_W    = $clog2(STRIPS);

  logic [WORD_W-1:0] merged;

  // finished strips kept from memory, new strip in its slot,
  // strips not yet blurred are written as zero
  for (genvar s = 0; s < STRIPS; s++) begin : g_strip
    assign merged[s*STRIP_W +: STRIP_W] =
      (SI_W'(s) < strip_idx)  ? blur_dout[s*STRIP_W +: STRIP_W] :
      (SI_W'(s) == strip_idx) ? strip_out :
                                '0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_din <= '0;
    end else begin
      blur_din <= merged;
    end
  end

endmodule

`default_nettype wire

/* logic/gaussian_blur_top.sv */
`timescale 1ns/10ps
`default_nettype none

module gaussian_blur_top #(
  parameter int  IMG_ROWS = img_geom_pkg::DEF_IMG_ROWS,
  parameter int  STRIPS   = img_geom_pkg::DEF_STRIPS,
  parameter int  STRIP_PX = img_geom_pkg::DEF_STRIP_PX,
  localparam int WORD_W   = STRIPS * STRIP_PX * img_geom_pkg::PIX_W,
  localparam int RA_W     = $clog2(IMG_ROWS)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  output logic              done,
  // image sram, one cycle read latency
  output logic              img_rd,
  output logic [RA_W-1:0]   img_addr,
  input  logic [WORD_W-1:0] img_dout,
  // blur sram, read every cycle, written by read-modify-write
  output logic [RA_W-1:0]   blur_raddr,
  input  logic [WORD_W-1:0] blur_dout,
  output logic              blur_we,
  output logic [RA_W-1:0]   blur_waddr,
  output logic [WORD_W-1:0] blur_din
);

  import img_geom_pkg::*;

  logic                      lb_shift;
  logic                      fill_zero;
  logic                      win_clear;
  logic [$clog2(STRIPS)-1:0] strip_idx;
  logic [WORD_W-1:0]         row_above;
  logic [WORD_W-1:0]         row_mid;
  logic [WORD_W-1:0]         row_below;
  pixel_t [STRIP_PX-1:0]     strip_out;

  blur_ctrl_fsm #(
    .IMG_ROWS (IMG_ROWS),
    .STRIPS   (STRIPS)
  ) u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .done       (done),
    .img_rd     (img_rd),
    .img_addr   (img_addr),
    .lb_shift   (lb_shift),
    .fill_zero  (fill_zero),
    .win_clear  (win_clear),
    .strip_idx  (strip_idx),
    .blur_raddr (blur_raddr),
    .blur_we    (blur_we),
    .blur_waddr (blur_waddr)
  );

  line_window #(
    .STRIPS   (STRIPS),
    .STRIP_PX (STRIP_PX)
  ) u_window (
    .clk       (clk),
    .rst_n     (rst_n),
    .lb_shift  (lb_shift),
    .fill_zero (fill_zero),
    .clear     (win_clear),
    .img_dout  (img_dout),
    .row_above (row_above),
    .row_mid   (row_mid),
    .row_below (row_below)
  );

  gauss_3x3_kernel #(
    .STRIPS   (STRIPS),
    .STRIP_PX (STRIP_PX)
  ) u_kernel (
    .clk       (clk),
    .rst_n     (rst_n),
    .row_above (row_above),
    .row_mid   (row_mid),
    .row_below (row_below),
    .strip_idx (strip_idx),
    .strip_out (strip_out)
  );

  strip_merge #(
    .STRIPS   (STRIPS),
    .STRIP_PX (STRIP_PX)
  ) u_merge (
    .clk       (clk),
    .rst_n     (rst_n),
    .strip_out (strip_out),
    .strip_idx (strip_idx),
    .blur_dout (blur_dout),
    .blur_din  (blur_din)
  );

endmodule

`default_nettype wire

/* sim/gaussian_blur_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module gaussian_blur_sva (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic done,
  input logic img_rd,
  input logic blur_we
);

  // high from start until done, low while the engine should be quiet
  logic seen_start;

  int quiet_fail_cnt = 0;
  int pulse_fail_cnt = 0;
  int done_we_fail_cnt = 0;
  int start_fail_cnt = 0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      seen_start <= 1'b0;
    end else if (done) begin
      seen_start <= 1'b0;
    end else if (start) begin
      seen_start <= 1'b1;
    end
  end

  // no strobes before the first start and between done and the next start
  a_quiet_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_start |-> !(done || img_rd || blur_we))
    else begin
      $error("strobe active while the engine is idle");
      quiet_fail_cnt++;
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done)
    else begin
      $error("done held high for more than one cycle");
      pulse_fail_cnt++;
    end

  // done follows the last write, it never coincides with one
  a_done_no_write: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> !blur_we)
    else begin
      $error("blur write in the done cycle");
      done_we_fail_cnt++;
    end

  a_start_prefetch: assert property (@(posedge clk) disable iff (!rst_n)
    (start && !seen_start) |=> img_rd)
    else begin
      $error("start in idle did not begin the prefetch");
      start_fail_cnt++;
    end

endmodule

bind gaussian_blur_top gaussian_blur_sva sva_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .start   (start),
  .done    (done),
  .img_rd  (img_rd),
  .blur_we (blur_we)
);

`default_nettype wire

/* sim/tb_gaussian_blur.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_gaussian_blur;

  import img_geom_pkg::*;
  import blur_kernel_pkg::*;

  localparam int IMG_ROWS   = DEF_IMG_ROWS;
  localparam int STRIPS     = DEF_STRIPS;
  localparam int STRIP_PX   = DEF_STRIP_PX;
  localparam int COLS       = STRIPS * STRIP_PX;
  localparam int STRIP_W    = STRIP_PX * PIX_W;
  localparam int WORD_W     = COLS * PIX_W;
  localparam int RA_W       = $clog2(IMG_ROWS);
  localparam int RUN_WRITES = STRIPS * IMG_ROWS;
  localparam int CLK_PERIOD = 20;
  // per strip: prefetch, row phase, pipe drain and the step, with margin
  localparam int RUN_CYCLES = STRIPS * (IMG_ROWS + 8) + 4;
  localparam int WATCHDOG_CYCLES = 4 * 2 * RUN_CYCLES;

  logic              clk;
  logic              rst_n;
  logic              start;
  logic              done;
  logic              img_rd;
  logic [RA_W-1:0]   img_addr;
  logic [WORD_W-1:0] img_dout = '0;
  logic [RA_W-1:0]   blur_raddr;
  logic [WORD_W-1:0] blur_dout = '0;
  logic              blur_we;
  logic [RA_W-1:0]   blur_waddr;
  logic [WORD_W-1:0] blur_din;

  logic [WORD_W-1:0] img_mem [IMG_ROWS];
  logic [WORD_W-1:0] blur_mem [IMG_ROWS];
  logic [WORD_W-1:0] ref_mem [IMG_ROWS];
  logic [15:0]       lfsr_state;
  logic              running;
  int                wr_cnt = 0;
  int                run_base = 0;
  int                chk_err_cnt = 0;
  int                end_err_cnt = 0;

  gaussian_blur_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .done       (done),
    .img_rd     (img_rd),
    .img_addr   (img_addr),
    .img_dout   (img_dout),
    .blur_raddr (blur_raddr),
    .blur_dout  (blur_dout),
    .blur_we    (blur_we),
    .blur_waddr (blur_waddr),
    .blur_din   (blur_din)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // image sram, data one cycle after the read strobe
  always @(posedge clk) begin
    if (img_rd) begin
      img_dout <= img_mem[img_addr];
    end
  end

  // blur sram, all ones after reset so stale strips would show up
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < IMG_ROWS; i++) begin
        blur_mem[i] <= '1;
      end
      blur_dout <= '0;
    end else begin
      blur_dout <= blur_mem[blur_raddr];
      if (blur_we) begin
        blur_mem[blur_waddr] <= blur_din;
      end
    end
  end

  // 16 bit fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic load_image();
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int b = 0; b < WORD_W; b++) begin
        lfsr_state = lfsr_next(lfsr_state);
        img_mem[r][b] = lfsr_state[0];
      end
    end
  endtask

  // zero outside the image on all four sides
  function automatic int pix_at(input int r, input int c);
    if (r < 0 || r >= IMG_ROWS || c < 0 || c >= COLS) begin
      return 0;
    end
    return int'(img_mem[r][c*PIX_W +: PIX_W]);
  endfunction

  task automatic compute_reference();
    int wt [3];
    int acc;
    wt[0] = W_EDGE;
    wt[1] = W_CENTER;
    wt[2] = W_EDGE;
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        acc = NORM_ROUND;
        for (int dr = 0; dr < 3; dr++) begin
          for (int dc = 0; dc < 3; dc++) begin
            acc += wt[dr] * wt[dc] * pix_at(r + dr - 1, c + dc - 1);
          end
        end
        ref_mem[r][c*PIX_W +: PIX_W] = pixel_t'(acc >> NORM_SHIFT);
      end
    end
  endtask

  // finished strips from memory, new strip from the reference, rest zero
  function automatic logic [WORD_W-1:0] expected_word(input int strip,
                                                      input logic [WORD_W-1:0] stored,
                                                      input logic [WORD_W-1:0] blurred);
    logic [WORD_W-1:0] w;
    w = '0;
    for (int s = 0; s < STRIPS; s++) begin
      if (s < strip) begin
        w[s*STRIP_W +: STRIP_W] = stored[s*STRIP_W +: STRIP_W];
      end else if (s == strip) begin
        w[s*STRIP_W +: STRIP_W] = blurred[s*STRIP_W +: STRIP_W];
      end
    end
    return w;
  endfunction

  // write checks, sampled mid cycle before the sram takes the word
  always @(negedge clk) begin
    int idx;
    int strip;
    logic [WORD_W-1:0] exp_word;
    if (rst_n && blur_we) begin
      idx   = wr_cnt - run_base;
      strip = idx / IMG_ROWS;
      assert (running)
        else begin
          $display("blur write at %0t while no run was active", $time);
          chk_err_cnt++;
        end
      assert (idx < RUN_WRITES)
        else begin
          $display("more than %0d blur writes in one run at %0t", RUN_WRITES, $time);
          chk_err_cnt++;
        end
      assert (blur_waddr == RA_W'(idx % IMG_ROWS))
        else begin
          $display("ERROR t=%0t blur_waddr: expected %0d, got %0d",
                   $time, idx % IMG_ROWS, blur_waddr);
          chk_err_cnt++;
        end
      if (idx < RUN_WRITES) begin
        exp_word = expected_word(strip, blur_mem[blur_waddr], ref_mem[blur_waddr]);
        assert (blur_din == exp_word)
          else begin
            $display("ERROR t=%0t blur_din (row %0d, strip %0d): expected %h, got %h",
                     $time, blur_waddr, strip, exp_word, blur_din);
            chk_err_cnt++;
          end
      end
      wr_cnt++;
    end
  end

  task automatic run_blur();
    @(posedge clk);
    run_base = wr_cnt;
    running  = 1'b1;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    do @(negedge clk); while (!done);
    assert (wr_cnt - run_base == RUN_WRITES)
      else begin
        $display("run ended after %0d writes instead of %0d", wr_cnt - run_base, RUN_WRITES);
        end_err_cnt++;
      end
    for (int r = 0; r < IMG_ROWS; r++) begin
      assert (blur_mem[r] == ref_mem[r])
        else begin
          $display("ERROR t=%0t blur_mem[%0d]: expected %h, got %h",
                   $time, r, ref_mem[r], blur_mem[r]);
          end_err_cnt++;
        end
    end
    @(posedge clk);
    running = 1'b0;
  endtask

  initial begin
    int sva_err_cnt;
    rst_n <= 1'b0;
    start <= 1'b0;
    running    = 1'b0;
    lfsr_state = 16'd23;
    load_image();
    compute_reference();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    run_blur();
    // fresh image, blur memory keeps the first result
    load_image();
    compute_reference();
    repeat (3) @(posedge clk);
    run_blur();
    repeat (5) @(posedge clk);
    sva_err_cnt = dut_i.sva_i.quiet_fail_cnt + dut_i.sva_i.pulse_fail_cnt
                + dut_i.sva_i.done_we_fail_cnt + dut_i.sva_i.start_fail_cnt;
    $display("errors: %0d write checks, %0d end of run checks, %0d assertions (%0d writes)",
             chk_err_cnt, end_err_cnt, sva_err_cnt, wr_cnt);
    if (chk_err_cnt + end_err_cnt + sva_err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, done never arrived", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
logic/img_geom_pkg.sv
logic/blur_kernel_pkg.sv
logic/blur_ctrl_fsm.sv
logic/line_window.sv
logic/gauss_3x3_kernel.sv
logic/strip_merge.sv
logic/gaussian_blur_top.sv
sim/gaussian_blur_sva.sv
sim/tb_gaussian_blur.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the blur testbench with Verilator and runs it
set -e
set -o pipefail
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_gaussian_blur \
  -f sources.f \
  -o tb_gaussian_blur

# bound assertions keep counting instead of stopping at the first one
./obj_dir/tb_gaussian_blur +verilator+error+limit+1000 | tee "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
grep -q "SIMULATION PASSED" "$LOG"
